// ==== bubblePkg.sv ====
`default_nettype none

package bubblePkg;

    // Access FSM states, encoded as {pageSelect, coilEnable, positionLatch}
    typedef enum logic [2:0] {
        initialStandby   = 3'b010, // Power-up, nothing selected
        bootloaderAccess = 3'b000, // Bootloop selected, coil running
        normalStandby    = 3'b110, // Page select high, coil stopped
        normalAccess     = 3'b100, // Coil running, waiting for latch
        pageLatch        = 3'b101  // Position latched, page goes out
    } accessState_t;

    // Per-bit output opcodes from the sequencer
    typedef enum logic [2:0] {
        modeIdle,      // Both lines high
        modeStartHigh, // First start-pattern bit
        modeStartLow,  // Second start-pattern bit
        modeData,      // Inverted buffer contents
        modeDummy,     // Trailing don't-care bits, high
        modeMarkLow    // Dummy low bits after the bootloader
    } outMode_t;

    typedef struct packed {
        logic positionChange; // 0 degree position step
        logic dataOutStrobe;  // Data goes out on its falling edge
        logic dataOutNotice;  // Replicator clamp
        logic positionLatch;  // Position may be latched
        logic pageSelect;     // Bootloader select
        logic coilEnable;     // Low while the bubbles move
    } timingStrobes_t;

    typedef struct packed {
        logic [10:0] address; // Buffer word address
        logic [1:0]  data;    // Odd in bit 1, even in bit 0
        logic        enable;  // Active low
    } bufferWrite_t;

    typedef struct packed {
        logic        advance; // One-cycle read strobe
        logic [10:0] address; // Word read on advance
    } readCommand_t;

    localparam logic [12:0] numPositions  = 13'd2053; // Positions 0..2052
    localparam logic [12:0] bootLength    = 13'd4571; // Bootloader bits 1..4571
    localparam logic [12:0] bootStartA    = 13'd2641; // Start pattern, odd high
    localparam logic [12:0] bootStartB    = 13'd2642; // Start pattern, both low
    localparam logic [12:0] bootDataFirst = 13'd2643;
    localparam logic [12:0] bootDataLast  = 13'd4562;
    localparam logic [12:0] bootDummyLast = 13'd4568; // End of low dummy bits
    localparam logic [12:0] pageLength    = 13'd703;  // Page bits 1..703
    localparam logic [12:0] pageDataFirst = 13'd101;
    localparam logic [12:0] pageDataLast  = 13'd612;

    localparam int channelCount = 2; // Odd and even

endpackage

`default_nettype wire

// ==== accessStateMachine.sv ====
`timescale 1ns/100ps
`default_nettype none

module accessStateMachine
(
    input  wire logic                       bubble_buffer_write_clock,
    input  wire logic                       bufferDataOutCounterEnable, // Async reset, active high
    input  wire bubblePkg::timingStrobes_t  strobes,
    output logic                            loadBootloader, // Active low
    output logic                            loadPage        // Active low
);

    import bubblePkg::*;

    logic [2:0]   lineSample;     // Registered control lines
    accessState_t state;          // Last accepted state
    accessState_t nextState;
    logic         nextBootloader;
    logic         nextPage;

    // Sample the three control lines once before decoding
    always_ff @(posedge bubble_buffer_write_clock or posedge bufferDataOutCounterEnable)
    begin
        if (bufferDataOutCounterEnable)
        begin
            lineSample <= initialStandby; // Quiet combination
        end
        else
        begin
            lineSample <= {strobes.pageSelect, strobes.coilEnable, strobes.positionLatch};
        end
    end

    // Decode with glitch filtering, default is hold
    always_comb
    begin
        nextState      = state;
        nextBootloader = loadBootloader;
        nextPage       = loadPage;
        case (lineSample)
            bootloaderAccess:
            begin
                if (!(state inside {normalAccess, pageLatch})) // D or E to B is a glitch
                begin
                    nextState      = bootloaderAccess;
                    nextBootloader = 1'b0;
                    nextPage       = 1'b1;
                end
            end
            initialStandby, normalStandby:
            begin
                if (state != pageLatch) // E to standby is a glitch
                begin
                    nextState      = accessState_t'(lineSample);
                    nextBootloader = 1'b1;
                    nextPage       = 1'b1;
                end
            end
            normalAccess:
            begin
                nextState = normalAccess; // Enables keep their level
            end
            pageLatch:
            begin
                if (state inside {normalAccess, pageLatch}) // Only D enters E
                begin
                    nextState      = pageLatch;
                    nextBootloader = 1'b1;
                    nextPage       = 1'b0;
                end
            end
            default:
            begin
                nextState = state; // Invalid line combination
            end
        endcase
    end

    always_ff @(posedge bubble_buffer_write_clock or posedge bufferDataOutCounterEnable)
    begin
        if (bufferDataOutCounterEnable)
        begin
            state          <= initialStandby;
            loadBootloader <= 1'b1;
            loadPage       <= 1'b1;
        end
        else
        begin
            state          <= nextState;
            loadBootloader <= nextBootloader;
            loadPage       <= nextPage;
        end
    end

    // Bootloader and page output never overlap
    enablesExclusive: assert property (@(posedge bubble_buffer_write_clock)
        disable iff (bufferDataOutCounterEnable) !(!loadBootloader && !loadPage));

endmodule

`default_nettype wire

// ==== positionCounter.sv ====
`timescale 1ns/100ps
`default_nettype none

module positionCounter
#(
    parameter logic [11:0] initialPosition = 12'd1464 // Per-unit calibration
)
(
    input  wire logic                       bubble_buffer_write_clock,
    input  wire logic                       bufferDataOutCounterEnable,
    input  wire bubblePkg::timingStrobes_t  strobes,
    output logic                            convert,
    output logic [11:0]                     bubblePositionOutput
);

    import bubblePkg::*;

    logic changeSample; // Registered positionChange
    logic changeLast;   // Previous sample
    logic changeRise;

    assign changeRise = changeSample & ~changeLast;

    always_ff @(posedge bubble_buffer_write_clock or posedge bufferDataOutCounterEnable)
    begin
        if (bufferDataOutCounterEnable)
        begin
            changeSample         <= 1'b0;
            changeLast           <= 1'b0;
            convert              <= 1'b0;
            bubblePositionOutput <= initialPosition;
        end
        else
        begin
            changeSample <= strobes.positionChange;
            changeLast   <= changeSample;
            convert      <= strobes.positionLatch; // Convert request follows the latch
            if (changeRise)
            begin
                if ({1'b0, bubblePositionOutput} >= numPositions - 13'd1)
                begin
                    bubblePositionOutput <= 12'd0; // Wrap after 2052
                end
                else
                begin
                    bubblePositionOutput <= bubblePositionOutput + 12'd1;
                end
            end
        end
    end

    positionInRange: assert property (@(posedge bubble_buffer_write_clock)
        disable iff (bufferDataOutCounterEnable) {1'b0, bubblePositionOutput} < numPositions);

endmodule

`default_nettype wire

// ==== outSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module outSequencer
(
    input  wire logic                       bubble_buffer_write_clock,
    input  wire logic                       bufferDataOutCounterEnable,
    input  wire bubblePkg::timingStrobes_t  strobes,
    input  wire logic                       loadBootloader, // Active low
    input  wire logic                       loadPage,       // Active low
    output bubblePkg::readCommand_t         readCommand,
    output bubblePkg::outMode_t             outMode
);

    import bubblePkg::*;

    logic        strobeSample;  // Registered dataOutStrobe
    logic        strobeLast;
    logic        strobeRise;
    logic        strobeFall;
    logic        sequenceIdle;  // Both enables released
    logic [12:0] bitLimit;      // Saturation point of the bit counter
    logic [12:0] bitCount;      // Bit number, 1-based once running
    logic        inDataWindow;
    logic [10:0] readAddress;   // Last address read, all ones outside a window
    outMode_t    nextMode;

    assign strobeRise   = strobeSample & ~strobeLast;
    assign strobeFall   = ~strobeSample & strobeLast;
    assign sequenceIdle = loadBootloader & loadPage;
    assign bitLimit     = loadBootloader ? pageLength : bootLength;

    always_ff @(posedge bubble_buffer_write_clock or posedge bufferDataOutCounterEnable)
    begin
        if (bufferDataOutCounterEnable)
        begin
            strobeSample <= 1'b0;
            strobeLast   <= 1'b0;
            bitCount     <= 13'd0;
        end
        else
        begin
            strobeSample <= strobes.dataOutStrobe;
            strobeLast   <= strobeSample;
            if (sequenceIdle)
            begin
                bitCount <= 13'd0; // Stopped between outputs
            end
            else if (strobeFall && bitCount < bitLimit)
            begin
                bitCount <= bitCount + 13'd1; // One per output bit
            end
        end
    end

    // Map the bit number onto an opcode
    always_comb
    begin
        nextMode     = modeIdle;
        inDataWindow = 1'b0;
        if (!loadBootloader)
        begin
            if (bitCount == bootStartA)
                nextMode = modeStartHigh;
            else if (bitCount == bootStartB)
                nextMode = modeStartLow;
            else if (bitCount >= bootDataFirst && bitCount <= bootDataLast)
            begin
                nextMode     = modeData;
                inDataWindow = 1'b1;
            end
            else if (bitCount > bootDataLast && bitCount <= bootDummyLast)
                nextMode = modeMarkLow; // Six low bits
            else if (bitCount > bootDummyLast)
                nextMode = modeDummy;
        end
        else if (!loadPage)
        begin
            if (bitCount >= pageDataFirst && bitCount <= pageDataLast)
            begin
                nextMode     = modeData;
                inDataWindow = 1'b1;
            end
            else if (bitCount > pageDataLast)
                nextMode = modeDummy;
        end
    end

    always_ff @(posedge bubble_buffer_write_clock or posedge bufferDataOutCounterEnable)
    begin
        if (bufferDataOutCounterEnable)
        begin
            outMode     <= modeIdle;
            readAddress <= '1;
        end
        else
        begin
            outMode <= nextMode; // One cycle behind the count
            if (!inDataWindow)
                readAddress <= '1; // First advance then reads 0
            else if (readCommand.advance)
                readAddress <= readCommand.address;
        end
    end

    assign readCommand = '{advance: strobeRise & inDataWindow,
                           address: readAddress + 11'd1};

    // Reads land after the opcode has switched to data
    advanceInData: assert property (@(posedge bubble_buffer_write_clock)
        disable iff (bufferDataOutCounterEnable) readCommand.advance |-> outMode == modeData);

endmodule

`default_nettype wire

// ==== channelBuffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module channelBuffer
(
    input  wire logic                       bubble_buffer_write_clock,
    input  wire logic [10:0]                writeAddress,
    input  wire logic                       writeBit,
    input  wire logic                       writeEnable, // Active low
    input  wire bubblePkg::readCommand_t    readCommand,
    output logic                            readBit
);

    localparam int depth = 2048; // One word per 11-bit address

    logic storage [depth];       // One channel of page or bootloader bits

    // Loader write port
    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (!writeEnable)
        begin
            storage[writeAddress] <= writeBit;
        end
    end

    // Sequenced read, held until the next advance
    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (readCommand.advance)
        begin
            readBit <= storage[readCommand.address];
        end
    end

endmodule

`default_nettype wire

// ==== outputMux.sv ====
`timescale 1ns/100ps
`default_nettype none

module outputMux
(
    input  wire bubblePkg::outMode_t    outMode,
    input  wire logic [1:0]             channelData,        // Odd in bit 1
    input  wire logic                   bubbleModuleEnable, // Active low
    output logic                        bubbleOutOdd,
    output logic                        bubbleOutEven
);

    import bubblePkg::*;

    localparam int oddChannel  = 1;
    localparam int evenChannel = 0;

    always_comb
    begin
        bubbleOutOdd  = 1'b1;
        bubbleOutEven = 1'b1;
        if (bubbleModuleEnable)
        begin
            bubbleOutOdd  = 1'b0; // Disabled module pulls both low
            bubbleOutEven = 1'b0;
        end
        else
        begin
            case (outMode)
                modeIdle, modeDummy:
                begin
                    bubbleOutOdd  = 1'b1;
                    bubbleOutEven = 1'b1;
                end
                modeStartHigh:
                begin
                    bubbleOutOdd  = 1'b1; // Start pattern, first half
                    bubbleOutEven = 1'b0;
                end
                modeStartLow, modeMarkLow:
                begin
                    bubbleOutOdd  = 1'b0;
                    bubbleOutEven = 1'b0;
                end
                modeData:
                begin
                    bubbleOutOdd  = ~channelData[oddChannel]; // Lines are inverted
                    bubbleOutEven = ~channelData[evenChannel];
                end
                default:
                begin
                    bubbleOutOdd  = 1'b1;
                    bubbleOutEven = 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== bubbleInterface.sv ====
`timescale 1ns/100ps
`default_nettype none

module bubbleInterface
#(
    parameter logic [11:0] initialPosition = 12'd1464 // Calibrated start position
)
(
    input  wire logic                       bubble_buffer_write_clock,
    input  wire logic                       bufferDataOutCounterEnable, // Async reset
    input  wire logic                       bubbleModuleEnable,         // Active low
    input  wire bubblePkg::timingStrobes_t  strobes,
    input  wire bubblePkg::bufferWrite_t    writePort,
    output logic                            convert,
    output logic [11:0]                     bubblePositionOutput,
    output logic                            loadPage,
    output logic                            loadBootloader,
    output logic                            bubbleOutOdd,
    output logic                            bubbleOutEven
);

    import bubblePkg::*;

    readCommand_t              readCommand; // Broadcast to all channels
    outMode_t                  outMode;
    logic [channelCount-1:0]   channelData; // Registered channel bits

    accessStateMachine uAccessStateMachine
    (
        .bubble_buffer_write_clock  (bubble_buffer_write_clock),
        .bufferDataOutCounterEnable (bufferDataOutCounterEnable),
        .strobes                    (strobes),
        .loadBootloader             (loadBootloader),
        .loadPage                   (loadPage)
    );

    positionCounter #(
        .initialPosition            (initialPosition)
    ) uPositionCounter
    (
        .bubble_buffer_write_clock  (bubble_buffer_write_clock),
        .bufferDataOutCounterEnable (bufferDataOutCounterEnable),
        .strobes                    (strobes),
        .convert                    (convert),
        .bubblePositionOutput       (bubblePositionOutput)
    );

    outSequencer uOutSequencer
    (
        .bubble_buffer_write_clock  (bubble_buffer_write_clock),
        .bufferDataOutCounterEnable (bufferDataOutCounterEnable),
        .strobes                    (strobes),
        .loadBootloader             (loadBootloader),
        .loadPage                   (loadPage),
        .readCommand                (readCommand),
        .outMode                    (outMode)
    );

    // One buffer per channel, same address and write strobe
    for (genvar ch = 0; ch < channelCount; ch++)
    begin : gChannel
        channelBuffer uChannelBuffer
        (
            .bubble_buffer_write_clock  (bubble_buffer_write_clock),
            .writeAddress               (writePort.address),
            .writeBit                   (writePort.data[ch]),
            .writeEnable                (writePort.enable),
            .readCommand                (readCommand),
            .readBit                    (channelData[ch])
        );
    end

    outputMux uOutputMux
    (
        .outMode                    (outMode),
        .channelData                (channelData),
        .bubbleModuleEnable         (bubbleModuleEnable),
        .bubbleOutOdd               (bubbleOutOdd),
        .bubbleOutEven              (bubbleOutEven)
    );

endmodule

`default_nettype wire

// ==== tbChecker.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbChecker
#(
    parameter logic [11:0] initialPosition = 12'd1464 // Must match the DUT
)
(
    input  wire logic                       bubble_buffer_write_clock,
    input  wire logic                       bufferDataOutCounterEnable,
    input  wire logic                       bubbleModuleEnable,   // Active low
    input  wire bubblePkg::timingStrobes_t  strobes,
    input  wire bubblePkg::bufferWrite_t    writePort,
    input  wire logic                       convert,
    input  wire logic [11:0]                bubblePositionOutput,
    input  wire logic                       loadPage,
    input  wire logic                       loadBootloader,
    input  wire logic                       bubbleOutOdd,
    input  wire logic                       bubbleOutEven
);

    import bubblePkg::*;

    localparam int lastPosition  = 2052; // Counter wraps to 0 after this
    localparam int startOddHigh  = 2641; // Odd high, even low
    localparam int startBothLow  = 2642;
    localparam int bootFirstData = 2643; // Reads address 0
    localparam int bootLastData  = 4562;
    localparam int bootLastLow   = 4568; // End of the six low bits
    localparam int pageFirstData = 101;
    localparam int pageLastData  = 612;

    logic [1:0]  shadow [2048];     // Loaded data, odd in bit 1
    logic [11:0] expectedPosition;  // Position model
    logic        changeLast;        // Previous positionChange level
    int          errorCount  = 0;   // All mismatches of the run
    int          testErrors  = 0;   // Mismatches of the running test
    int          testCount   = 0;
    int          failedTests = 0;

    // Snoop the loader port
    always @(posedge bubble_buffer_write_clock)
    begin
        if (!writePort.enable)
            shadow[writePort.address] <= writePort.data;
    end

    // One step per rising edge of positionChange
    always @(posedge bubble_buffer_write_clock or posedge bufferDataOutCounterEnable)
    begin
        if (bufferDataOutCounterEnable)
        begin
            expectedPosition <= initialPosition;
            changeLast       <= 1'b0;
        end
        else
        begin
            changeLast <= strobes.positionChange;
            if (strobes.positionChange && !changeLast)
                expectedPosition <= (expectedPosition == 12'(lastPosition)) ? 12'd0
                                                                           : expectedPosition + 12'd1;
        end
    end

    task automatic compareBit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("mismatch at %0d ns: %s expected %b got %b", $time, name, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic checkEnables(input logic expBoot, input logic expPage);
        compareBit("loadBootloader", loadBootloader, expBoot);
        compareBit("loadPage", loadPage, expPage);
    endtask

    // Nothing sequenced yet, lines high unless disabled
    task automatic checkIdle();
        compareBit("bubbleOutOdd", bubbleOutOdd, ~bubbleModuleEnable);
        compareBit("bubbleOutEven", bubbleOutEven, ~bubbleModuleEnable);
    endtask

    task automatic checkPosition();
        if (bubblePositionOutput !== expectedPosition)
        begin
            $display("mismatch at %0d ns: bubblePositionOutput expected %0d got %0d",
                     $time, expectedPosition, bubblePositionOutput);
            errorCount++;
            testErrors++;
        end
        compareBit("convert", convert, strobes.positionLatch); // Follows the latch line
    endtask

    // Expected {odd, even} for bit k of a page or bootloader output
    task automatic checkBit(input int k, input logic boot);
        logic [1:0]  expected;
        logic [10:0] address;
        expected = 2'b11;
        if (boot)
        begin
            if (k == startOddHigh)
                expected = 2'b10;
            else if (k == startBothLow)
                expected = 2'b00;
            else if (k >= bootFirstData && k <= bootLastData)
            begin
                address  = 11'(k - bootFirstData);
                expected = ~shadow[address]; // Lines carry inverted data
            end
            else if (k > bootLastData && k <= bootLastLow)
                expected = 2'b00;
        end
        else if (k >= pageFirstData && k <= pageLastData)
        begin
            address  = 11'(k - pageFirstData);
            expected = ~shadow[address];
        end
        if (bubbleModuleEnable)
            expected = 2'b00; // Disabled module
        compareBit($sformatf("bubbleOutOdd bit %0d", k), bubbleOutOdd, expected[1]);
        compareBit($sformatf("bubbleOutEven bit %0d", k), bubbleOutEven, expected[0]);
    endtask

    task automatic endTest(input string name);
        testCount++;
        if (testErrors == 0)
            $display("test %0d %s: passed", testCount, name);
        else
        begin
            failedTests++;
            $display("test %0d %s: failed with %0d mismatches", testCount, name, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic reportCounts();
        $display("tests %0d, passed %0d, failed %0d, mismatches %0d",
                 testCount, testCount - failedTests, failedTests, errorCount);
    endtask

endmodule

`default_nettype wire

// ==== tbBubbleInterface.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbBubbleInterface;

    import bubblePkg::*;

    localparam logic [11:0] initialPosition = 12'd1464;
    localparam int bitHalf        = 20;     // Half of the 40-cycle bit period
    localparam int pageBits       = 703;
    localparam int bootBits       = 4571;
    localparam int positionPulses = 590;    // 1464 up past the wrap at 2052
    localparam int cycleLimit     = 500000; // Whole run, about 400k cycles needed
    localparam int numRows        = 23;

    typedef enum logic [1:0] {lineRow, positionRow, pageRow, bootRow} rowKind_t;

    typedef struct packed {
        rowKind_t   kind;
        logic [2:0] lines;    // {pageSelect, coilEnable, positionLatch}
        logic       expBoot;  // Expected loadBootloader
        logic       expPage;  // Expected loadPage
        logic       disabled; // bubbleModuleEnable level
    } row_t;

    logic           bubble_buffer_write_clock;
    logic           bufferDataOutCounterEnable;
    logic           bubbleModuleEnable;
    timingStrobes_t strobes;
    bufferWrite_t   writePort;
    logic           convert;
    logic [11:0]    bubblePositionOutput;
    logic           loadPage;
    logic           loadBootloader;
    logic           bubbleOutOdd;
    logic           bubbleOutEven;

    row_t stimulus [numRows] = '{
        '{lineRow,     3'b010, 1'b1, 1'b1, 1'b0}, // Reset state
        '{lineRow,     3'b000, 1'b0, 1'b1, 1'b0}, // Bootloader access
        '{lineRow,     3'b111, 1'b0, 1'b1, 1'b0}, // Invalid, hold
        '{lineRow,     3'b101, 1'b0, 1'b1, 1'b0}, // Latch only from normal access
        '{lineRow,     3'b011, 1'b0, 1'b1, 1'b0}, // Invalid
        '{lineRow,     3'b010, 1'b1, 1'b1, 1'b0},
        '{lineRow,     3'b110, 1'b1, 1'b1, 1'b0}, // Normal standby
        '{lineRow,     3'b100, 1'b1, 1'b1, 1'b0}, // Normal access holds
        '{lineRow,     3'b000, 1'b1, 1'b1, 1'b0}, // Glitch to bootloader
        '{lineRow,     3'b101, 1'b1, 1'b0, 1'b0}, // Page latch
        '{lineRow,     3'b000, 1'b1, 1'b0, 1'b0}, // Glitch
        '{lineRow,     3'b110, 1'b1, 1'b0, 1'b0}, // Glitch to standby
        '{lineRow,     3'b010, 1'b1, 1'b0, 1'b0},
        '{lineRow,     3'b001, 1'b1, 1'b0, 1'b0}, // Invalid
        '{lineRow,     3'b100, 1'b1, 1'b0, 1'b0}, // Back to access, enables kept
        '{lineRow,     3'b110, 1'b1, 1'b1, 1'b0},
        '{lineRow,     3'b101, 1'b1, 1'b1, 1'b0}, // Latch from standby ignored
        '{lineRow,     3'b010, 1'b1, 1'b1, 1'b1}, // Idle while disabled
        '{positionRow, 3'b010, 1'b1, 1'b1, 1'b0},
        '{pageRow,     3'b101, 1'b1, 1'b0, 1'b0},
        '{bootRow,     3'b000, 1'b0, 1'b1, 1'b0},
        '{bootRow,     3'b000, 1'b0, 1'b1, 1'b1}, // Every mode while disabled
        '{lineRow,     3'b010, 1'b1, 1'b1, 1'b0}
    };

    bubbleInterface #(
        .initialPosition            (initialPosition)
    ) u_dut
    (
        .bubble_buffer_write_clock  (bubble_buffer_write_clock),
        .bufferDataOutCounterEnable (bufferDataOutCounterEnable),
        .bubbleModuleEnable         (bubbleModuleEnable),
        .strobes                    (strobes),
        .writePort                  (writePort),
        .convert                    (convert),
        .bubblePositionOutput       (bubblePositionOutput),
        .loadPage                   (loadPage),
        .loadBootloader             (loadBootloader),
        .bubbleOutOdd               (bubbleOutOdd),
        .bubbleOutEven              (bubbleOutEven)
    );

    tbChecker #(
        .initialPosition            (initialPosition)
    ) checks
    (
        .bubble_buffer_write_clock  (bubble_buffer_write_clock),
        .bufferDataOutCounterEnable (bufferDataOutCounterEnable),
        .bubbleModuleEnable         (bubbleModuleEnable),
        .strobes                    (strobes),
        .writePort                  (writePort),
        .convert                    (convert),
        .bubblePositionOutput       (bubblePositionOutput),
        .loadPage                   (loadPage),
        .loadBootloader             (loadBootloader),
        .bubbleOutOdd               (bubbleOutOdd),
        .bubbleOutEven              (bubbleOutEven)
    );

    initial
    begin
        bubble_buffer_write_clock = 1'b0;
        forever #2 bubble_buffer_write_clock = ~bubble_buffer_write_clock; // 4 ns period
    end

    initial
    begin
        for (int cycle = 0; cycle < cycleLimit; cycle++)
            @(posedge bubble_buffer_write_clock);
        $display("timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("STATUS: FAIL");
        $finish;
    end

    // Step n cycles, landing 1 ns after the edge
    task automatic settle(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            @(posedge bubble_buffer_write_clock);
            #1;
        end
    endtask

    task automatic setLines(input logic [2:0] lines);
        strobes.pageSelect    = lines[2];
        strobes.coilEnable    = lines[1];
        strobes.positionLatch = lines[0];
    endtask

    task automatic fillBuffer();
        for (int a = 0; a < 2048; a++)
        begin
            writePort = '{address: 11'(a), data: 2'($urandom), enable: 1'b0};
            settle(1);
        end
        writePort.enable = 1'b1;
        settle(1);
    endtask

    task automatic runBits(input int count, input logic boot);
        for (int k = 1; k <= count; k++)
        begin
            strobes.dataOutStrobe = 1'b0; // Falling edge starts bit k
            settle(bitHalf);
            strobes.dataOutStrobe = 1'b1; // Rising edge reads the buffer
            settle(bitHalf - 1);
            checks.checkBit(k, boot);     // Last cycle of bit k
            settle(1);
        end
    endtask

    task automatic runPosition();
        checks.checkPosition(); // Still at the calibration value
        for (int i = 0; i < positionPulses; i++)
        begin
            strobes.positionLatch  = i[0];
            strobes.positionChange = 1'b1;
            settle(2);
            strobes.positionChange = 1'b0;
            settle(2);
            checks.checkPosition();
        end
        strobes.positionLatch = 1'b0;
        settle(2);
    endtask

    task automatic runPage(input row_t row);
        setLines(3'b110);
        settle(4);
        setLines(3'b100);
        settle(4);
        setLines(3'b101);
        settle(4);
        checks.checkEnables(row.expBoot, row.expPage);
        runBits(pageBits, 1'b0);
        setLines(3'b100); // Leave through normal access
        settle(4);
        setLines(3'b110);
        settle(4);
        checks.checkEnables(1'b1, 1'b1);
    endtask

    task automatic runBoot(input row_t row);
        setLines(3'b000);
        settle(4);
        checks.checkEnables(row.expBoot, row.expPage);
        runBits(bootBits, 1'b1);
        setLines(3'b010);
        settle(4);
        checks.checkEnables(1'b1, 1'b1);
    endtask

    task automatic applyRow(input row_t row);
        string name;
        bubbleModuleEnable = row.disabled;
        case (row.kind)
            lineRow:
            begin
                setLines(row.lines);
                settle(4); // Sample plus state register
                checks.checkEnables(row.expBoot, row.expPage);
                checks.checkIdle();
                name = $sformatf("lines %b", row.lines);
            end
            positionRow:
            begin
                runPosition();
                name = "position counter";
            end
            pageRow:
            begin
                runPage(row);
                name = "page output";
            end
            default:
            begin
                runBoot(row);
                name = "bootloader output";
            end
        endcase
        if (row.disabled)
            name = {name, " disabled"};
        checks.endTest(name);
    endtask

    initial
    begin
        void'($urandom(32'hf4e3a161));
        bufferDataOutCounterEnable = 1'b1;
        bubbleModuleEnable         = 1'b0;
        strobes   = '{positionChange: 1'b0, dataOutStrobe: 1'b1, dataOutNotice: 1'b0,
                      positionLatch: 1'b0, pageSelect: 1'b0, coilEnable: 1'b1};
        writePort = '{address: 11'd0, data: 2'b00, enable: 1'b1};
        repeat (4) @(posedge bubble_buffer_write_clock);
        #1;
        bufferDataOutCounterEnable = 1'b0;
        fillBuffer();
        for (int r = 0; r < numRows; r++)
            applyRow(stimulus[r]);
        checks.reportCounts();
        if (checks.errorCount == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
bubblePkg.sv
accessStateMachine.sv
positionCounter.sv
outSequencer.sv
channelBuffer.sv
outputMux.sv
bubbleInterface.sv
tbChecker.sv
tbBubbleInterface.sv

// ==== Makefile ====
# Verilator build and run of the bubble memory output interface testbench

VERILATOR ?= verilator
TOP       ?= tbBubbleInterface
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_TEXT ?= STATUS: FAIL

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A crashed or aborted run counts as a failure
run: compile
	./$(BINARY) > $(LOG) 2>&1 || echo "$(FAIL_TEXT)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
